// ==== src.f ====
+incdir+rtl
rtl/dram_pkg.sv
rtl/row_open_if.sv
rtl/row_open.sv
rtl/req_queue.sv
rtl/cmd_sequencer.sv
rtl/dram_ctrl_top.sv
test/clk_gen.sv
test/tb_dram_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the DRAM scheduler testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_dram_ctrl
LOG=sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module "$TOP" -o "$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== test/tb_dram_ctrl.sv ====
// Assumes the DRAM takes every command, refresh may trail T_REFI by up to REF_SLACK cycles
`timescale 1ns/1ps
`default_nettype none
`include "dram_params.svh"

module tb_dram_ctrl;
    import dram_pkg::*;

    localparam int IDX_W      = `BG_BITS + `BANK_BITS;
    localparam int NBANK      = 1 << IDX_W;
    localparam int WAIT_LIMIT = 400;   // Cycles per wait loop
    localparam int REF_SLACK  = 32;    // One request may finish before refresh
    localparam int BURST_LEN  = 40;

    logic                  CLK;
    logic                  nRST;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_write;
    logic [`ADDR_BITS-1:0] req_addr;
    logic                  cmd_valid;
    dram_cmd_t             cmd_op;
    logic [`BG_BITS-1:0]   cmd_bank_group;
    logic [`BANK_BITS-1:0] cmd_bank;
    logic [`ROW_BITS-1:0]  cmd_row;
    logic [`COL_BITS-1:0]  cmd_col;
    logic                  all_row_closed;

    // Shadow of the DRAM rows, built only from observed commands
    logic [NBANK-1:0]      open_vld;
    logic [`ROW_BITS-1:0]  open_row [NBANK];
    logic [`ADDR_BITS:0]   exp_q [$];     // {write, addr} in acceptance order
    logic                  req_started;   // Head request already issued a command
    logic                  saw_full;
    int                    since_act;
    int                    since_pre;
    int                    since_ref;
    int                    ref_age;
    int                    ref_count;
    int                    check_errors;
    int                    timeout_errors;
    integer                seed;

    clk_gen #(.PERIOD(100)) u_clk (.CLK(CLK));

    dram_ctrl_top UUT (
        .CLK           (CLK),
        .nRST          (nRST),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_bank_group(cmd_bank_group),
        .cmd_bank      (cmd_bank),
        .cmd_row       (cmd_row),
        .cmd_col       (cmd_col),
        .all_row_closed(all_row_closed)
    );

    task automatic report_mismatch(input string msg);
        check_errors++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    function automatic logic [`ADDR_BITS-1:0] pack_addr(input logic [`ROW_BITS-1:0] row,
            input logic [`BG_BITS-1:0] bg, input logic [`BANK_BITS-1:0] bank,
            input logic [`COL_BITS-1:0] col);
        return {row, bg, bank, col};
    endfunction

    // Hit starts with RD/WR, miss with ACT, conflict with PRE
    task automatic check_first_cmd(input dram_cmd_t op, input logic [`ADDR_BITS:0] head);
        logic [`ROW_BITS-1:0] h_row;
        logic [IDX_W-1:0]     h_idx;
        dram_cmd_t            exp_op;
        h_row = head[`ADDR_BITS-1 -: `ROW_BITS];
        h_idx = head[`COL_BITS +: IDX_W];
        if (!open_vld[h_idx]) begin
            exp_op = CMD_ACT;
        end else if (open_row[h_idx] == h_row) begin
            exp_op = head[`ADDR_BITS] ? CMD_WR : CMD_RD;
        end else begin
            exp_op = CMD_PRE;
        end
        assert (op == exp_op) else report_mismatch($sformatf(
            "request starts with %s, expected %s", op.name(), exp_op.name()));
        req_started = 1'b1;
    endtask

    task automatic check_cmd();
        logic [IDX_W-1:0]     idx;
        logic [`ADDR_BITS:0]  head;
        logic [`ROW_BITS-1:0] h_row;
        logic                 is_req;
        idx    = {cmd_bank_group, cmd_bank};
        head   = (exp_q.size() > 0) ? exp_q[0] : '0;
        h_row  = head[`ADDR_BITS-1 -: `ROW_BITS];
        is_req = cmd_op inside {CMD_ACT, CMD_PRE, CMD_RD, CMD_WR};
        if (is_req && exp_q.size() == 0) begin
            report_mismatch($sformatf("%s with no pending request", cmd_op.name()));
        end else begin
            if (is_req) begin
                if (!req_started) begin
                    check_first_cmd(cmd_op, head);
                end
                assert (idx == head[`COL_BITS +: IDX_W]) else report_mismatch($sformatf(
                    "%s to bank %0d, request is for bank %0d", cmd_op.name(), idx,
                    head[`COL_BITS +: IDX_W]));
            end
            case (cmd_op)
                CMD_ACT: begin
                    assert (!open_vld[idx]) else report_mismatch("ACT to a bank already open");
                    assert (cmd_row == h_row) else report_mismatch($sformatf(
                        "ACT row %0h, expected %0h", cmd_row, h_row));
                    open_vld[idx] = 1'b1;
                    open_row[idx] = cmd_row;
                end
                CMD_PRE: begin
                    assert (open_vld[idx] && open_row[idx] == cmd_row)
                        else report_mismatch($sformatf("PRE row %0h is not the open row", cmd_row));
                    open_vld[idx] = 1'b0;
                end
                CMD_PREA: begin
                    assert (open_vld != '0) else report_mismatch("PREA with every bank closed");
                    open_vld = '0;
                end
                CMD_REF: begin
                    assert (open_vld == '0) else report_mismatch("REF while rows are open");
                    ref_count++;
                end
                CMD_RD, CMD_WR: begin
                    assert (cmd_row == h_row && cmd_col == head[`COL_BITS-1:0]
                        && (cmd_op == CMD_WR) == head[`ADDR_BITS])
                        else report_mismatch($sformatf("%s row %0h col %0h, expected %0h %0h wr %0b",
                            cmd_op.name(), cmd_row, cmd_col, h_row, head[`COL_BITS-1:0],
                            head[`ADDR_BITS]));
                    assert (open_vld[idx] && open_row[idx] == cmd_row)
                        else report_mismatch("RD/WR to a row that is not open");
                    void'(exp_q.pop_front());
                    req_started = 1'b0;
                end
                default: report_mismatch($sformatf("unexpected command code %0d", cmd_op));
            endcase
        end
    endtask

    // Monitor, all DUT outputs are stable at the rising edge
    always @(posedge CLK) begin
        if (nRST) begin
            if (req_valid && req_ready) begin
                exp_q.push_back({req_write, req_addr});
            end
            if (req_valid && !req_ready) begin
                saw_full = 1'b1;
            end
            if (cmd_valid) begin
                check_cmd();
            end
        end
    end

    // Cycles since the last command of each kind
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            since_act <= 1000;
            since_pre <= 1000;
            since_ref <= 1000;
            ref_age   <= 0;
        end else begin
            since_act <= (cmd_valid && cmd_op == CMD_ACT) ? 1 : since_act + 1;
            since_pre <= (cmd_valid && cmd_op inside {CMD_PRE, CMD_PREA}) ? 1 : since_pre + 1;
            since_ref <= (cmd_valid && cmd_op == CMD_REF) ? 1 : since_ref + 1;
            ref_age   <= (cmd_valid && cmd_op == CMD_REF) ? 0 : ref_age + 1;
        end
    end

    a_rcd: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_valid && cmd_op inside {CMD_RD, CMD_WR}) |-> (since_act >= `T_RCD))
        else report_mismatch("RD/WR closer to ACT than tRCD");

    a_rp: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_valid && cmd_op inside {CMD_ACT, CMD_REF}) |-> (since_pre >= `T_RP))
        else report_mismatch("ACT or REF closer to PRE or PREA than tRP");

    a_rfc: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_valid && cmd_op != CMD_REF) |-> (since_ref >= `T_RFC))
        else report_mismatch("command closer to REF than tRFC");

    a_ref_closes: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_valid && cmd_op == CMD_REF) |=> all_row_closed)
        else report_mismatch("all_row_closed low after REF");

    a_refi: assert property (@(posedge CLK) disable iff (!nRST)
        ref_age <= `T_REFI + REF_SLACK)
        else report_mismatch("refresh interval exceeded");

    // Holds valid from a falling edge until a rising edge sees ready
    task automatic send_req(input logic wr, input logic [`ADDR_BITS-1:0] addr);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        if (!req_ready) begin
            timeout_errors++;
            $display("Timeout: request %0h was not accepted in %0d cycles", addr, WAIT_LIMIT);
        end
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("Timeout: %0d requests never got their RD/WR", exp_q.size());
        end
    endtask

    task automatic wait_refresh();
        int cycles;
        int start;
        cycles = 0;
        start  = ref_count;
        while (ref_count == start && cycles < `T_REFI + WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (ref_count == start) begin
            timeout_errors++;
            $display("Timeout: no REF command within %0d cycles", cycles);
        end
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        seed           = 35729;
        nRST           = 1'b0;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        open_vld       = '0;
        req_started    = 1'b0;
        saw_full       = 1'b0;
        ref_count      = 0;
        check_errors   = 0;
        timeout_errors = 0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        assert (!cmd_valid && all_row_closed && req_ready)
            else report_mismatch("outputs not idle after reset");

        send_req(1'b0, pack_addr(12'h0A5, 2'd2, 2'd1, 8'h10));   // Miss
        send_req(1'b1, pack_addr(12'h0A5, 2'd2, 2'd1, 8'h11));   // Hit
        send_req(1'b0, pack_addr(12'h3C0, 2'd2, 2'd1, 8'h12));   // Conflict
        send_req(1'b1, pack_addr(12'h111, 2'd0, 2'd3, 8'h20));
        wait_drain();
        wait_refresh();                                          // Rows open, so PREA first
        send_req(1'b0, pack_addr(12'h3C0, 2'd2, 2'd1, 8'h13));   // Closed by refresh
        wait_drain();

        // Few banks and rows so hits and conflicts mix
        for (i = 0; i < BURST_LEN; i++) begin
            r = $random(seed);
            send_req(r[0], pack_addr({10'd0, r[6:5]}, {1'b0, r[3]}, {1'b0, r[4]}, r[15:8]));
        end
        wait_drain();

        if (!saw_full) begin
            check_errors++;
            $display("Queue never filled during the random burst");
        end
        if (ref_count == 0) begin
            check_errors++;
            $display("No REF command was seen");
        end
        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
// Free-running testbench clock, starts low, PERIOD in ns
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic CLK
);
    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;  // Half period per edge
        end
    end
endmodule

`default_nettype wire

// ==== rtl/dram_ctrl_top.sv ====
// Single-rank command scheduler, the DRAM side has no ready and accepts every command
`timescale 1ns/1ps
`default_nettype none
`include "dram_params.svh"

module dram_ctrl_top (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [`ADDR_BITS-1:0] req_addr,
    output logic                  cmd_valid,
    output dram_pkg::dram_cmd_t   cmd_op,
    output logic [`BG_BITS-1:0]   cmd_bank_group,
    output logic [`BANK_BITS-1:0] cmd_bank,
    output logic [`ROW_BITS-1:0]  cmd_row,
    output logic [`COL_BITS-1:0]  cmd_col,
    output logic                  all_row_closed
);
    import dram_pkg::*;

    dram_req_t in_req;
    dram_req_t q_req;   // Head of the queue
    logic      q_valid;
    logic      q_ready;

    row_open_if pol ();

    assign in_req = '{write: req_write, addr: req_addr};

    req_queue #(
        .DEPTH(`QUEUE_DEPTH)
    ) u_queue (
        .CLK      (CLK),
        .nRST     (nRST),
        .in_valid (req_valid),
        .in_ready (req_ready),
        .in_req   (in_req),
        .out_valid(q_valid),
        .out_ready(q_ready),
        .out_req  (q_req)
    );

    cmd_sequencer u_seq (
        .CLK           (CLK),
        .nRST          (nRST),
        .req_valid     (q_valid),
        .req_ready     (q_ready),
        .req           (q_req),
        .pol           (pol.seq),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_bank_group(cmd_bank_group),
        .cmd_bank      (cmd_bank),
        .cmd_row       (cmd_row),
        .cmd_col       (cmd_col)
    );

    row_open u_row_open (
        .CLK (CLK),
        .nRST(nRST),
        .pol (pol.dut)
    );

    assign all_row_closed = pol.all_row_closed;

endmodule

`default_nettype wire

// ==== rtl/cmd_sequencer.sv ====
// One request in flight, no reordering, refresh waits for the current request to finish
`timescale 1ns/1ps
`default_nettype none
`include "dram_params.svh"

module cmd_sequencer (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dram_pkg::dram_req_t   req,
    row_open_if.seq               pol,
    output logic                  cmd_valid,
    output dram_pkg::dram_cmd_t   cmd_op,
    output logic [`BG_BITS-1:0]   cmd_bank_group,
    output logic [`BANK_BITS-1:0] cmd_bank,
    output logic [`ROW_BITS-1:0]  cmd_row,
    output logic [`COL_BITS-1:0]  cmd_col
);
    import dram_pkg::*;

    localparam int GAP_W  = $clog2(`T_RFC + 1);
    localparam int REFI_W = $clog2(`T_REFI);

    typedef enum logic [2:0] {
        IDLE, PRECHARGE, WAIT_RP, ACTIVATE, WAIT_RCD, ACCESS, REF_PREA, REF_WAIT
    } state_t;

    state_t                state;
    state_t                state_n;
    logic [GAP_W-1:0]      gap_cnt;   // Shared by tRP, tRCD and tRFC
    logic [REFI_W-1:0]     refi_cnt;
    logic                  ref_pend;
    logic                  ref_sent;  // REF already out in this refresh
    logic                  gap_done;
    logic                  in_ref;
    logic                  issue_ref;
    logic [`ROW_BITS-1:0]  req_row;
    logic [`BG_BITS-1:0]   req_bg;
    logic [`BANK_BITS-1:0] req_bank;
    logic [`COL_BITS-1:0]  req_col;

    assign {req_row, req_bg, req_bank, req_col} = req.addr;

    assign in_ref    = (state == REF_PREA) || (state == REF_WAIT);
    assign gap_done  = (gap_cnt <= GAP_W'(1));
    assign issue_ref = (state == REF_WAIT) && gap_done && !ref_sent;
    assign req_ready = (state == ACCESS);  // Pop on RD/WR

    // Tracker side
    assign pol.req_en      = req_valid && !in_ref;
    assign pol.bank_group  = req_bg;
    assign pol.bank        = req_bank;
    assign pol.row         = req_row;
    assign pol.row_resolve = (state == PRECHARGE);
    assign pol.tACT_done   = (state == ACTIVATE);
    assign pol.refresh     = issue_ref;

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (ref_pend) begin
                    state_n = REF_PREA;  // Refresh wins between requests
                end else if (req_valid) begin
                    case (pol.row_stat)
                        ROW_HIT:      state_n = ACCESS;
                        ROW_MISS:     state_n = ACTIVATE;
                        ROW_CONFLICT: state_n = PRECHARGE;
                        default:      state_n = IDLE;
                    endcase
                end
            end
            PRECHARGE: state_n = WAIT_RP;
            WAIT_RP:   if (gap_done) state_n = ACTIVATE;
            ACTIVATE:  state_n = WAIT_RCD;
            WAIT_RCD:  if (gap_done) state_n = ACCESS;
            ACCESS:    state_n = IDLE;
            REF_PREA:  state_n = REF_WAIT;
            REF_WAIT:  if (gap_done && ref_sent) state_n = IDLE;
            default:   state_n = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            gap_cnt  <= '0;
            ref_sent <= 1'b0;
        end else begin
            state <= state_n;
            case (state)
                PRECHARGE: gap_cnt <= GAP_W'(`T_RP - 1);
                REF_PREA:  gap_cnt <= GAP_W'(`T_RP);  // REF leaves from REF_WAIT itself
                ACTIVATE:  gap_cnt <= GAP_W'(`T_RCD - 1);
                default: begin
                    if (issue_ref) begin
                        gap_cnt <= GAP_W'(`T_RFC - 1);
                    end else if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
            endcase
            if (state == REF_PREA) begin
                ref_sent <= 1'b0;
            end else if (issue_ref) begin
                ref_sent <= 1'b1;
            end
        end
    end

    // Free-running refresh interval timer
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            refi_cnt <= '0;
            ref_pend <= 1'b0;
        end else begin
            if (issue_ref) begin
                ref_pend <= 1'b0;
            end
            if (refi_cnt == REFI_W'(`T_REFI - 1)) begin
                refi_cnt <= '0;
                ref_pend <= 1'b1;
            end else begin
                refi_cnt <= refi_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        cmd_valid = 1'b0;
        cmd_op    = CMD_NOP;
        case (state)
            PRECHARGE: begin
                cmd_valid = 1'b1;
                cmd_op    = CMD_PRE;
            end
            ACTIVATE: begin
                cmd_valid = 1'b1;
                cmd_op    = CMD_ACT;
            end
            ACCESS: begin
                cmd_valid = 1'b1;
                cmd_op    = req.write ? CMD_WR : CMD_RD;
            end
            REF_PREA: begin
                cmd_valid = !pol.all_row_closed;  // Skip PREA when nothing is open
                cmd_op    = pol.all_row_closed ? CMD_NOP : CMD_PREA;
            end
            REF_WAIT: begin
                cmd_valid = issue_ref;
                cmd_op    = issue_ref ? CMD_REF : CMD_NOP;
            end
            default: ;
        endcase
    end

    assign cmd_bank_group = req_bg;
    assign cmd_bank       = req_bank;
    assign cmd_row        = (state == PRECHARGE) ? pol.row_conflict : req_row;
    assign cmd_col        = req_col;

    // A wait state never repeats the command of the cycle before
    a_wait_no_repeat: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_valid && (state == WAIT_RP || state == WAIT_RCD || state == REF_WAIT))
        |-> !($past(cmd_valid) && $past(cmd_op) == cmd_op))
        else $error("cmd_sequencer: command repeated in a wait state");

    // Column access only to a row the tracker sees as open
    a_access_on_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_valid && (cmd_op == CMD_RD || cmd_op == CMD_WR)) |-> (pol.row_stat == ROW_HIT))
        else $error("cmd_sequencer: RD/WR issued without a row hit");

endmodule

`default_nettype wire

// ==== rtl/req_queue.sv ====
// Request FIFO without bypass, a pushed entry shows on the output one cycle later
`timescale 1ns/1ps
`default_nettype none
`include "dram_params.svh"

module req_queue #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                in_valid,
    output logic                in_ready,
    input  dram_pkg::dram_req_t in_req,
    output logic                out_valid,
    input  logic                out_ready,
    output dram_pkg::dram_req_t out_req
);
    import dram_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dram_req_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_req   = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= in_req;
        end
    end

    // Full and not drained, so the head entry must survive untouched
    a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
        (count == CNT_W'(DEPTH) && !out_ready)
        |=> (count == CNT_W'(DEPTH) && out_req == $past(out_req)))
        else $error("req_queue: entry written while full");

    // The consumer only pops a valid head
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST)
        out_ready |-> out_valid)
        else $error("req_queue: pop requested while empty");

endmodule

`default_nettype wire

// ==== rtl/row_open.sv ====
// Open-row table, DEPTH must cover every bank group and bank, updates only while req_en is high
`timescale 1ns/1ps
`default_nettype none
`include "dram_params.svh"

module row_open #(
    parameter int DEPTH = 1 << (`BG_BITS + `BANK_BITS)
) (
    input logic     CLK,
    input logic     nRST,
    row_open_if.dut pol
);
    import dram_pkg::*;

    localparam int IDX_W = `BG_BITS + `BANK_BITS;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0]     row_vld;            // One open flag per bank
    logic [`ROW_BITS-1:0] row_tag [DEPTH];    // Open row per bank
    logic [CNT_W-1:0]     open_cnt;
    logic [IDX_W-1:0]     idx;
    row_stat_t            stat;
    logic [`ROW_BITS-1:0] conflict_row;
    logic                 open_row;
    logic                 close_row;

    assign idx = {pol.bank_group, pol.bank};

    // Classify the request against the table
    always_comb begin
        stat = ROW_IDLE;
        conflict_row = '0;
        if (pol.req_en) begin
            if (!row_vld[idx]) begin
                stat = ROW_MISS;
            end else if (row_tag[idx] == pol.row) begin
                stat = ROW_HIT;
            end else begin
                stat = ROW_CONFLICT;
                conflict_row = row_tag[idx];  // Row the PRE has to close
            end
        end
    end

    assign pol.row_stat       = stat;
    assign pol.row_conflict   = conflict_row;
    assign pol.all_row_closed = (open_cnt == '0);

    assign open_row  = pol.req_en && pol.tACT_done && (stat == ROW_MISS);
    assign close_row = pol.req_en && pol.row_resolve && row_vld[idx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            row_vld  <= '0;
            open_cnt <= '0;
        end else if (pol.refresh) begin
            row_vld  <= '0;  // REF leaves every bank closed
            open_cnt <= '0;
        end else if (open_row) begin
            row_vld[idx] <= 1'b1;
            open_cnt     <= open_cnt + 1'b1;
        end else if (close_row) begin
            row_vld[idx] <= 1'b0;
            open_cnt     <= open_cnt - 1'b1;
        end
    end

    // Row address of the bank being opened
    always_ff @(posedge CLK) begin
        if (open_row) begin
            row_tag[idx] <= pol.row;
        end
    end

    // The sequencer never activates and precharges in the same cycle
    a_act_vs_pre: assert property (@(posedge CLK) disable iff (!nRST)
        !(pol.tACT_done && pol.row_resolve))
        else $error("row_open: tACT_done and row_resolve high together");

endmodule

`default_nettype wire

// ==== rtl/row_open_if.sv ====
// Sequencer to tracker link, row_stat is combinational on req_en and the address fields
`timescale 1ns/1ps
`default_nettype none
`include "dram_params.svh"

interface row_open_if;
    import dram_pkg::*;

    // Driven by the sequencer
    logic                  req_en;
    logic [`BG_BITS-1:0]   bank_group;
    logic [`BANK_BITS-1:0] bank;
    logic [`ROW_BITS-1:0]  row;
    logic                  row_resolve;   // PRE issued on a conflict
    logic                  tACT_done;     // ACT issued
    logic                  refresh;       // REF issued

    // Driven by the tracker
    row_stat_t             row_stat;
    logic [`ROW_BITS-1:0]  row_conflict;  // Row currently open in a conflicting bank
    logic                  all_row_closed;

    modport dut (
        input  req_en, bank_group, bank, row, row_resolve, tACT_done, refresh,
        output row_stat, row_conflict, all_row_closed
    );

    modport seq (
        output req_en, bank_group, bank, row, row_resolve, tACT_done, refresh,
        input  row_stat, row_conflict, all_row_closed
    );

endinterface

`default_nettype wire

// ==== rtl/dram_pkg.sv ====
// Types shared by the controller, address layout is {row, bank group, bank, column}
`default_nettype none
`include "dram_params.svh"

package dram_pkg;

    // One request word as it sits in the queue
    typedef struct packed {
        logic                  write;  // 1 = WR, 0 = RD
        logic [`ADDR_BITS-1:0] addr;
    } dram_req_t;

    // Command codes on the DRAM side
    typedef enum logic [2:0] {
        CMD_NOP  = 3'd0,
        CMD_ACT  = 3'd1,
        CMD_PRE  = 3'd2,
        CMD_PREA = 3'd3,
        CMD_RD   = 3'd4,
        CMD_WR   = 3'd5,
        CMD_REF  = 3'd6
    } dram_cmd_t;

    // Tracker answer, only meaningful while req_en is high
    typedef enum logic [1:0] {
        ROW_IDLE     = 2'd0,
        ROW_HIT      = 2'd1,
        ROW_MISS     = 2'd2,
        ROW_CONFLICT = 2'd3
    } row_stat_t;

endpackage

`default_nettype wire

// ==== rtl/dram_params.svh ====
// Widths assume a single rank of 2^(BG_BITS+BANK_BITS) banks, and T_RFC must be the largest gap
`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

// Address fields, row on top and column at the bottom
`define ROW_BITS   12
`define BG_BITS    2
`define BANK_BITS  2
`define COL_BITS   8
`define ADDR_BITS  (`ROW_BITS + `BG_BITS + `BANK_BITS + `COL_BITS)

`define QUEUE_DEPTH 4   // Pending requests

// Timing in controller clock cycles
`define T_RP    3     // PRE or PREA to ACT
`define T_RCD   3     // ACT to RD or WR
`define T_REFI  200   // Refresh interval
`define T_RFC   8     // REF to next command

`endif
